// ==== rtl/axi_pkg.sv ====
// AXI4 memory bus widths, beat types and response/burst codes, imported by every bus-facing module
package axi_pkg;

  ////////////////////
  // Bus widths
  ////////////////////
  localparam int AXI_ADDR_BITS = 32;                   // Byte address
  localparam int AXI_DATA_BITS = 64;                   // One beat
  localparam int AXI_STRB_BITS = AXI_DATA_BITS / 8;    // One strobe bit per byte

  typedef logic [AXI_ADDR_BITS-1:0] axi_addr_t;        // Byte address
  typedef logic [AXI_DATA_BITS-1:0] axi_data_t;        // Data beat
  typedef logic [AXI_STRB_BITS-1:0] axi_strb_t;        // Byte enables
  typedef logic [7:0]               axi_len_t;         // Beats minus one
  typedef logic [1:0]               axi_resp_t;        // B channel response

  ////////////////////
  // Codes
  ////////////////////
  localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;       // Normal completion
  localparam logic [2:0] AXI_SIZE_BEAT  = 3'd3;        // 8 bytes, full bus width
  localparam logic [1:0] AXI_BURST_INCR = 2'd1;        // Incrementing burst

endpackage

// ==== rtl/cdma_pkg.sv ====
// Write DMA command widths, burst limits and FSM encodings, imported by the engine modules
package cdma_pkg;

  ////////////////////
  // Command and burst sizing
  ////////////////////
  localparam int LEN_BITS    = 16;                     // Command length in beats
  localparam int BURST_BEATS = 16;                     // Max beats per AW burst
  localparam int OUTSTANDING = 4;                      // Burst-count queue depth

  typedef logic [LEN_BITS-1:0] cdma_len_t;             // Length in beats
  typedef logic [4:0]          cnt_t;                  // Beats within one burst, 1..16

  ////////////////////
  // State machines
  ////////////////////
  typedef enum logic [1:0] {
    CMD_IDLE,                                          // Ready for a command
    CMD_RUN,                                           // Waiting on responses
    CMD_DONE                                           // One-cycle done pulse
  } cmd_state_t;

  typedef enum logic [1:0] {
    AW_IDLE,                                           // No command held
    AW_ISSUE,                                          // awvalid high
    AW_WAIT                                            // Queue full, hold off
  } aw_state_t;

  // Bursts needed for a command, length over BURST_BEATS rounded up
  function automatic cdma_len_t cdma_bursts(input cdma_len_t len);
    return cdma_len_t'(len / BURST_BEATS) + cdma_len_t'((len % BURST_BEATS) != 0);
  endfunction

endpackage

// ==== rtl/cdma_wr_cmd_reg.sv ====
// Write DMA command register: takes one command, counts AW bursts and B responses, flags done
module cdma_wr_cmd_reg (
  input  logic                aclk,
  input  logic                rst_n,

  input  logic                wr_valid,
  output logic                wr_ready,
  input  axi_pkg::axi_addr_t  wr_paddr,
  input  cdma_pkg::cdma_len_t wr_len,
  output logic                wr_done,
  output logic                wr_error,

  output logic                cmd_start,
  output axi_pkg::axi_addr_t  cmd_addr,
  output cdma_pkg::cdma_len_t cmd_len,
  input  logic                aw_fire,

  input  logic                bvalid,
  input  axi_pkg::axi_resp_t  bresp
);

  import axi_pkg::*;
  import cdma_pkg::*;

  cmd_state_t state;
  cdma_len_t  exp_bursts;                              // Bursts this command needs
  cdma_len_t  resp_cnt;                                // B responses seen
  cdma_len_t  resp_nxt;
  cdma_len_t  aw_cnt;                                  // AW handshakes seen
  logic       err_q;                                   // Sticky non-OKAY flag
  logic       accept;

  assign wr_ready = (state == CMD_IDLE);
  assign accept   = wr_valid && wr_ready;
  assign resp_nxt = resp_cnt + cdma_len_t'(1);
  assign wr_done  = (state == CMD_DONE);
  assign wr_error = err_q;                             // Final once wr_done rises

  ////////////////////
  // Command hold
  ////////////////////
  always_ff @(posedge aclk) begin
    if (accept) begin
      cmd_addr   <= wr_paddr;
      cmd_len    <= wr_len;
      exp_bursts <= cdma_bursts(wr_len);               // Computed once per command
    end
  end

  ////////////////////
  // Control FSM
  ////////////////////
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state     <= CMD_IDLE;
      cmd_start <= 1'b0;
      resp_cnt  <= '0;
      aw_cnt    <= '0;
      err_q     <= 1'b0;
    end else begin
      cmd_start <= 1'b0;                               // Pulse by default low
      case (state)
        CMD_IDLE: begin
          if (accept) begin
            state     <= CMD_RUN;
            cmd_start <= 1'b1;                         // Held regs valid next cycle
            resp_cnt  <= '0;
            aw_cnt    <= '0;
            err_q     <= 1'b0;                         // Fresh error per command
          end
        end
        CMD_RUN: begin
          if (aw_fire)
            aw_cnt <= aw_cnt + cdma_len_t'(1);
          if (bvalid) begin                            // bready tied high
            resp_cnt <= resp_nxt;
            if (bresp != AXI_RESP_OKAY)
              err_q <= 1'b1;
            if (resp_nxt == exp_bursts)
              state <= CMD_DONE;                       // Last response in
          end
        end
        CMD_DONE: state <= CMD_IDLE;                   // Done lasts one cycle
        default:  state <= CMD_IDLE;
      endcase
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  a_cmd_legal: assert property (@(posedge aclk) disable iff (!rst_n)
    accept |-> (wr_len != '0) && (wr_paddr[$clog2(AXI_STRB_BITS)-1:0] == '0))
    else $error("command with zero length or unaligned address");

  a_aw_bound: assert property (@(posedge aclk) disable iff (!rst_n)
    (state != CMD_IDLE) |-> (aw_cnt <= exp_bursts))
    else $error("more AW bursts issued than the command needs");

  a_b_idle: assert property (@(posedge aclk) disable iff (!rst_n)
    bvalid |-> (state != CMD_IDLE))
    else $error("write response with no command active");

endmodule

// ==== rtl/cdma_wr_burst_gen.sv ====
// Write DMA burst generator: cuts the held command into AW bursts, queues beat counts for W
module cdma_wr_burst_gen (
  input  logic                aclk,
  input  logic                rst_n,

  input  logic                cmd_start,
  input  axi_pkg::axi_addr_t  cmd_addr,
  input  cdma_pkg::cdma_len_t cmd_len,

  output axi_pkg::axi_addr_t  awaddr,
  output axi_pkg::axi_len_t   awlen,
  output logic [2:0]          awsize,
  output logic [1:0]          awburst,
  output logic                awvalid,
  input  logic                awready,
  output logic                aw_fire,

  output logic                q_valid,
  output cdma_pkg::cnt_t      q_beats,
  input  logic                q_pop
);

  import axi_pkg::*;
  import cdma_pkg::*;

  aw_state_t state;
  axi_addr_t addr_q;                                   // Address of burst on AW
  cnt_t      beats_q;                                  // Beats of burst on AW
  cdma_len_t remain_q;                                 // Beats after this burst
  cnt_t      first_beats;
  cnt_t      nxt_beats;

  // Beat queue, one entry per issued burst
  cnt_t                         q_mem [OUTSTANDING];
  logic [$clog2(OUTSTANDING)-1:0] wr_ptr;
  logic [$clog2(OUTSTANDING)-1:0] rd_ptr;
  logic [$clog2(OUTSTANDING):0]   q_cnt;
  logic [$clog2(OUTSTANDING):0]   q_cnt_nxt;
  logic                           q_full;

  // Burst size capped at BURST_BEATS
  function automatic cnt_t burst_of(input cdma_len_t beats);
    return (beats > cdma_len_t'(BURST_BEATS)) ? cnt_t'(BURST_BEATS) : cnt_t'(beats);
  endfunction

  assign first_beats = burst_of(cmd_len);
  assign nxt_beats   = burst_of(remain_q);

  ////////////////////
  // AW channel
  ////////////////////
  assign awvalid = (state == AW_ISSUE);
  assign aw_fire = awvalid && awready;
  assign awaddr  = addr_q;
  assign awlen   = axi_len_t'(beats_q - cnt_t'(1));   // AXI length is beats minus one
  assign awsize  = AXI_SIZE_BEAT;
  assign awburst = AXI_BURST_INCR;

  always_ff @(posedge aclk) begin
    if (state == AW_IDLE && cmd_start) begin
      addr_q   <= cmd_addr;
      beats_q  <= first_beats;
      remain_q <= cmd_len - cdma_len_t'(first_beats);
    end else if (aw_fire && remain_q != '0) begin
      addr_q   <= addr_q + axi_addr_t'(beats_q) * AXI_STRB_BITS;  // Step past last burst
      beats_q  <= nxt_beats;
      remain_q <= remain_q - cdma_len_t'(nxt_beats);
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state <= AW_IDLE;
    end else begin
      case (state)
        AW_IDLE:  if (cmd_start) state <= AW_ISSUE;    // Queue drained by now
        AW_ISSUE: begin
          if (aw_fire) begin
            if (remain_q == '0)
              state <= AW_IDLE;                        // Command fully issued
            else if (q_cnt_nxt == OUTSTANDING)
              state <= AW_WAIT;                        // No room for next burst
          end
        end
        AW_WAIT:  if (!q_full) state <= AW_ISSUE;
        default:  state <= AW_IDLE;
      endcase
    end
  end

  ////////////////////
  // Burst-count queue
  ////////////////////
  assign q_full    = (q_cnt == OUTSTANDING);
  assign q_valid   = (q_cnt != '0);
  assign q_beats   = q_mem[rd_ptr];
  assign q_cnt_nxt = q_cnt + aw_fire - q_pop;

  always_ff @(posedge aclk) begin
    if (aw_fire)
      q_mem[wr_ptr] <= beats_q;
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (aw_fire) wr_ptr <= wr_ptr + 1'b1;            // Wraps at depth
      if (q_pop)   rd_ptr <= rd_ptr + 1'b1;
      q_cnt <= q_cnt_nxt;
    end
  end

  a_q_push: assert property (@(posedge aclk) disable iff (!rst_n)
    aw_fire |-> !q_full)
    else $error("burst queue pushed while full");

endmodule

// ==== rtl/cdma_wr_data_mover.sv ====
// Write DMA data mover: forwards stream beats to AXI W and places wlast from queued beat counts
module cdma_wr_data_mover (
  input  logic               aclk,
  input  logic               rst_n,

  input  axi_pkg::axi_data_t s_axis_tdata,
  input  axi_pkg::axi_strb_t s_axis_tkeep,
  input  logic               s_axis_tlast,
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,

  output axi_pkg::axi_data_t wdata,
  output axi_pkg::axi_strb_t wstrb,
  output logic               wlast,
  output logic               wvalid,
  input  logic               wready,

  input  logic               q_valid,
  input  cdma_pkg::cnt_t     q_beats,
  output logic               q_pop
);

  import cdma_pkg::*;

  cnt_t      beat_cnt;                                 // Beat index in burst
  cdma_len_t cmd_beat_q;                               // Beats so far in command
  logic      w_fire;

  ////////////////////
  // Stream to W
  ////////////////////
  assign wvalid        = s_axis_tvalid && q_valid;     // Only with a burst queued
  assign s_axis_tready = wready && q_valid;            // W stall stalls stream
  assign wdata         = s_axis_tdata;
  assign wstrb         = s_axis_tkeep;                 // tkeep maps onto wstrb
  assign w_fire        = wvalid && wready;
  assign wlast         = (beat_cnt == q_beats - cnt_t'(1));
  assign q_pop         = w_fire && wlast;              // Burst done, drop head

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (w_fire) begin
      beat_cnt <= wlast ? '0 : beat_cnt + cnt_t'(1);
    end
  end

  // Command beat count, restarts after tlast
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      cmd_beat_q <= '0;
    end else if (w_fire) begin
      cmd_beat_q <= s_axis_tlast ? '0 : cmd_beat_q + cdma_len_t'(1);
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  // tlast must close the command's tail burst exactly
  a_tlast_align: assert property (@(posedge aclk) disable iff (!rst_n)
    (w_fire && s_axis_tlast) |->
      wlast && (q_beats == cnt_t'(cmd_beat_q % BURST_BEATS) + cnt_t'(1)))
    else $error("tlast does not line up with the last burst's wlast");

  // Short burst only ever at the end of a command
  a_short_last: assert property (@(posedge aclk) disable iff (!rst_n)
    (q_pop && q_beats != cnt_t'(BURST_BEATS)) |-> s_axis_tlast)
    else $error("short burst ended without tlast");

endmodule

// ==== rtl/cdma_wr_top.sv ====
// Write DMA top: connects command register, burst generator and data mover to AXI and stream
module cdma_wr_top (
  input  logic                aclk,
  input  logic                rst_n,

  // Command
  input  logic                wr_valid,
  output logic                wr_ready,
  input  axi_pkg::axi_addr_t  wr_paddr,
  input  cdma_pkg::cdma_len_t wr_len,
  output logic                wr_done,
  output logic                wr_error,

  // Stream in
  input  axi_pkg::axi_data_t  s_axis_tdata,
  input  axi_pkg::axi_strb_t  s_axis_tkeep,
  input  logic                s_axis_tlast,
  input  logic                s_axis_tvalid,
  output logic                s_axis_tready,

  // AXI write master
  output axi_pkg::axi_addr_t  awaddr,
  output axi_pkg::axi_len_t   awlen,
  output logic [2:0]          awsize,
  output logic [1:0]          awburst,
  output logic                awvalid,
  input  logic                awready,
  output axi_pkg::axi_data_t  wdata,
  output axi_pkg::axi_strb_t  wstrb,
  output logic                wlast,
  output logic                wvalid,
  input  logic                wready,
  input  axi_pkg::axi_resp_t  bresp,
  input  logic                bvalid,
  output logic                bready
);

  import axi_pkg::*;
  import cdma_pkg::*;

  logic      cmd_start;                                // Command latched
  axi_addr_t cmd_addr;
  cdma_len_t cmd_len;
  logic      aw_fire;                                  // AW handshake
  logic      q_valid;                                  // Burst queued for W
  cnt_t      q_beats;
  logic      q_pop;

  assign bready = 1'b1;                                // Responses never stalled

  ////////////////////
  // Engine blocks
  ////////////////////
  cdma_wr_cmd_reg inst_cmd_reg (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr_paddr  (wr_paddr),
    .wr_len    (wr_len),
    .wr_done   (wr_done),
    .wr_error  (wr_error),
    .cmd_start (cmd_start),
    .cmd_addr  (cmd_addr),
    .cmd_len   (cmd_len),
    .aw_fire   (aw_fire),
    .bvalid    (bvalid),
    .bresp     (bresp)
  );

  cdma_wr_burst_gen inst_burst_gen (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .cmd_start (cmd_start),
    .cmd_addr  (cmd_addr),
    .cmd_len   (cmd_len),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .awsize    (awsize),
    .awburst   (awburst),
    .awvalid   (awvalid),
    .awready   (awready),
    .aw_fire   (aw_fire),
    .q_valid   (q_valid),
    .q_beats   (q_beats),
    .q_pop     (q_pop)
  );

  cdma_wr_data_mover inst_data_mover (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wlast         (wlast),
    .wvalid        (wvalid),
    .wready        (wready),
    .q_valid       (q_valid),
    .q_beats       (q_beats),
    .q_pop         (q_pop)
  );

endmodule

// ==== verif/axi_mem_model.sv ====
// AXI4 write slave for the DMA testbench: word memory, random ready stalls, per-burst error inject
module axi_mem_model (
  input  logic               aclk,
  input  logic               rst_n,
  input  logic               log_clr,     // Clears the AW log between commands
  input  logic [7:0]         err_idx,     // Burst that gets SLVERR
  input  axi_pkg::axi_addr_t awaddr,
  input  axi_pkg::axi_len_t  awlen,
  input  logic [2:0]         awsize,
  input  logic [1:0]         awburst,
  input  logic               awvalid,
  output logic               awready,
  input  axi_pkg::axi_data_t wdata,
  input  axi_pkg::axi_strb_t wstrb,
  input  logic               wlast,
  input  logic               wvalid,
  output logic               wready,
  output axi_pkg::axi_resp_t bresp,
  output logic               bvalid,
  input  logic               bready
);
  timeunit 1ns;
  timeprecision 1ps;
  import axi_pkg::*;

  localparam int WORDS  = 1024;                        // 8 KB of 64-bit words
  localparam int MAX_AW = 16;

  axi_data_t mem [WORDS];
  axi_addr_t aw_addr_log [MAX_AW];                     // AW history of current command
  axi_len_t  aw_len_log [MAX_AW];
  int        aw_n;                                     // AW handshakes since clear
  int        w_idx;                                    // Burst taking W beats
  int        w_beat;                                   // Beat within that burst
  int        proto_err;                                // Bad wlast or AW codes

  // Fill tracks the whole word index
  initial begin
    for (int i = 0; i < WORDS; i++)
      mem[i] = {~32'(i), 32'(i)};
  end

  always @(posedge aclk) begin : slave
    int word_idx;
    if (!rst_n) begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= AXI_RESP_OKAY;
      aw_n      <= 0;
      w_idx     <= 0;
      w_beat    <= 0;
      proto_err <= 0;
    end else begin
      awready <= ($urandom % 4) != 0;                  // Stall about one cycle in four
      wready  <= ($urandom % 4) != 0;
      if (!bvalid || bready) begin
        bvalid <= wvalid && wready && wlast;           // One response per burst
        bresp  <= (w_idx == int'(err_idx)) ? 2'b10 : AXI_RESP_OKAY;  // SLVERR on chosen burst
      end
      if (log_clr) begin
        aw_n   <= 0;
        w_idx  <= 0;
        w_beat <= 0;
      end
      if (awvalid && awready && aw_n < MAX_AW) begin
        aw_addr_log[aw_n] <= awaddr;
        aw_len_log[aw_n]  <= awlen;
        aw_n              <= aw_n + 1;
        if (awsize != 3'd3 || awburst != 2'd1)
          proto_err <= proto_err + 1;
      end
      if (wvalid && wready) begin
        word_idx = int'(aw_addr_log[w_idx] >> 3) + w_beat;
        for (int b = 0; b < AXI_STRB_BITS; b++)
          if (wstrb[b])
            mem[word_idx % WORDS][8*b +: 8] <= wdata[8*b +: 8];
        // wlast only on the final beat of a logged burst
        if (w_idx >= aw_n || wlast != (w_beat == int'(aw_len_log[w_idx])))
          proto_err <= proto_err + 1;
        if (wlast) begin
          w_idx  <= w_idx + 1;
          w_beat <= 0;
        end else begin
          w_beat <= w_beat + 1;
        end
      end
    end
  end

endmodule

// ==== verif/cdma_wr_tb.sv ====
// Testbench for the write DMA engine that applies a command table and checks memory, bursts and done
module cdma_wr_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_pkg::*;
  import cdma_pkg::*;

  localparam int         N_CMDS  = 7;
  localparam logic [7:0] NO_ERR  = 8'hFF;              // No burst gets an error
  localparam axi_data_t  PATTERN = 64'hA5C3_0F1E_5A3C_F0E1;

  typedef struct packed {
    axi_addr_t  addr;                                  // Beat-aligned start
    cdma_len_t  len;                                   // Beats
    logic [7:0] err_burst;                             // Burst index forced to SLVERR
    logic       exp_err;                               // Expected wr_error
  } entry_t;

  // Ranges kept apart so neighbour words stay at the fill value
  entry_t tbl [N_CMDS] = '{
    '{32'h0000_0100, 16'd1,  NO_ERR, 1'b0},
    '{32'h0000_0200, 16'd16, 8'd0,   1'b1},
    '{32'h0000_0400, 16'd17, NO_ERR, 1'b0},
    '{32'h0000_0800, 16'd40, 8'd2,   1'b1},
    '{32'h0000_0C08, 16'd17, 8'd1,   1'b1},
    '{32'h0000_1800, 16'd80, 8'd3,   1'b1},            // Five bursts fill the queue
    '{32'h0000_1000, 16'd40, NO_ERR, 1'b0}
  };

  logic      aclk;
  logic      rst_n;
  logic      wr_valid, wr_ready, wr_done, wr_error;
  axi_addr_t wr_paddr;
  cdma_len_t wr_len;
  axi_data_t s_axis_tdata;
  axi_strb_t s_axis_tkeep;
  logic      s_axis_tlast, s_axis_tvalid, s_axis_tready;
  axi_addr_t awaddr;
  axi_len_t  awlen;
  logic [2:0] awsize;
  logic [1:0] awburst;
  logic      awvalid, awready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wlast, wvalid, wready;
  axi_resp_t bresp;
  logic      bvalid, bready;
  logic      log_clr;
  logic [7:0] err_idx;
  int        errors = 0;
  int        checks = 0;

  cdma_wr_top uut (.*);
  axi_mem_model mem_slave (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;                          // 20 ns period
  end

  ////////////////////
  // Helpers
  ////////////////////
  function automatic axi_data_t beat_data(input int word);
    return axi_data_t'(word) ^ PATTERN;
  endfunction

  function automatic axi_data_t untouched_word(input int word);
    return {~32'(word), 32'(word)};
  endfunction

  function automatic int total_beats();
    int sum;
    sum = 0;
    for (int i = 0; i < N_CMDS; i++)
      sum += int'(tbl[i].len);
    return sum;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %0t: %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic issue_cmd(input axi_addr_t addr, input cdma_len_t len);
    wr_valid <= 1'b1;
    wr_paddr <= addr;
    wr_len   <= len;
    do @(posedge aclk); while (!wr_ready);             // Accepted at this edge
    wr_valid <= 1'b0;
  endtask

  task automatic send_stream(input axi_addr_t addr, input cdma_len_t len);
    int gap;
    int word;
    word = int'(addr >> 3);
    for (int b = 0; b < int'(len); b++) begin
      gap = $urandom % 3;                              // Random tvalid holes
      if (gap != 0) begin
        s_axis_tvalid <= 1'b0;
        repeat (gap) @(posedge aclk);
      end
      s_axis_tvalid <= 1'b1;
      s_axis_tdata  <= beat_data(word + b);
      s_axis_tkeep  <= '1;
      s_axis_tlast  <= (b == int'(len) - 1);
      do @(posedge aclk); while (!s_axis_tready);
    end
    s_axis_tvalid <= 1'b0;
    s_axis_tlast  <= 1'b0;
  endtask

  task automatic wait_done(input logic exp_err);
    do begin
      @(posedge aclk);
      check("wr_ready while busy", wr_ready, 0);
      check("bready held high", bready, 1);
    end while (!wr_done);
    check("wr_error", wr_error, exp_err);
    repeat (2) begin
      @(posedge aclk);
      check("single wr_done pulse", wr_done, 0);
      check("wr_ready after done", wr_ready, 1);
    end
  endtask

  task automatic run_cmd(input int idx);
    axi_addr_t addr;
    cdma_len_t len;
    int        base;
    int        n_bursts;
    int        left;
    addr    = tbl[idx].addr;
    len     = tbl[idx].len;
    base    = int'(addr >> 3);
    err_idx <= tbl[idx].err_burst;
    log_clr <= 1'b1;
    @(posedge aclk);
    log_clr <= 1'b0;
    fork
      begin
        issue_cmd(addr, len);
        wait_done(tbl[idx].exp_err);
      end
      send_stream(addr, len);
    join
    // Bursts split at the 16-beat limit with contiguous addresses
    n_bursts = (int'(len) + BURST_BEATS - 1) / BURST_BEATS;
    left     = int'(len);
    check("burst count", mem_slave.aw_n, n_bursts);
    for (int k = 0; k < n_bursts; k++) begin
      check("awaddr", mem_slave.aw_addr_log[k], addr + axi_addr_t'(8 * BURST_BEATS * k));
      check("awlen", mem_slave.aw_len_log[k], ((left > BURST_BEATS) ? BURST_BEATS : left) - 1);
      left -= BURST_BEATS;
    end
    check("wlast placement", mem_slave.proto_err, 0);
    for (int w = 0; w < int'(len); w++)
      check("memory word", mem_slave.mem[base + w], beat_data(base + w));
    check("word below range", mem_slave.mem[base - 1], untouched_word(base - 1));
    check("word above range", mem_slave.mem[base + int'(len)], untouched_word(base + int'(len)));
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    void'($urandom(19665));
    $timeformat(-9, 0, " ns", 0);
    rst_n         = 1'b0;
    wr_valid      = 1'b0;
    wr_paddr      = '0;
    wr_len        = '0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tlast  = 1'b0;
    s_axis_tvalid = 1'b0;
    log_clr       = 1'b0;
    err_idx       = NO_ERR;
    repeat (4) @(posedge aclk);
    rst_n <= 1'b1;
    @(posedge aclk);
    check("wr_ready after reset", wr_ready, 1);
    check("wr_done after reset", wr_done, 0);
    check("awvalid after reset", awvalid, 0);
    check("wvalid after reset", wvalid, 0);
    check("s_axis_tready after reset", s_axis_tready, 0);
    for (int i = 0; i < N_CMDS; i++)
      run_cmd(i);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog allows 40 cycles per beat plus a margin
  initial begin : watchdog
    int limit;
    limit = total_beats() * 40 + 200;
    repeat (limit) @(posedge aclk);
    $display("Timeout: the DMA did not finish all commands within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== sources.f ====
rtl/axi_pkg.sv
rtl/cdma_pkg.sv
rtl/cdma_wr_cmd_reg.sv
rtl/cdma_wr_burst_gen.sv
rtl/cdma_wr_data_mover.sv
rtl/cdma_wr_top.sv
verif/axi_mem_model.sv
verif/cdma_wr_tb.sv

// ==== Makefile ====
TOP := cdma_wr_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f sources.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
